// File: hdl/pkt_pkg.sv
/*
 * Shared definitions for the stream to packet framer
 * Field widths and typedefs, packet type codes,
 * header size constant and header word field positions
 */

package pkt_pkg;

   // Field widths
   localparam int SAMPLE_W = 32;
   localparam int WORD_W   = 64;
   localparam int TIME_W   = 64;
   localparam int SIZE_W   = 14;
   localparam int BURST_W  = 48;
   localparam int SEQ_W    = 8;
   localparam int FLOW_W   = 32;

   // I in the upper half, Q in the lower half
   typedef logic [SAMPLE_W-1:0] sample_t;
   typedef logic [WORD_W-1:0]   word_t;
   typedef logic [TIME_W-1:0]   pkt_time_t;
   typedef logic [SIZE_W-1:0]   pkt_size_t;
   typedef logic [BURST_W-1:0]  burst_cnt_t;
   typedef logic [SEQ_W-1:0]    seq_id_t;
   typedef logic [FLOW_W-1:0]   flow_id_t;

   typedef enum logic [7:0] {
      PKT_INT16_COMPLEX     = 8'h16,
      PKT_INT16_COMPLEX_EOB = 8'h17
   } pkt_type_t;

   // Header and time words, counted in 32-bit words
   localparam int HEADER_WORDS = 4;

   // ------------------------------------------------------------
   // Header word layout
   // ------------------------------------------------------------
   localparam int HDR_TYPE_LSB = 56;
   localparam int HDR_SEQ_LSB  = 48;
   localparam int HDR_SIZE_LSB = 32;
   localparam int HDR_SIZE_W   = 16;
   localparam int HDR_FLOW_LSB = 0;

endpackage

// File: hdl/pkt_ifs.sv
/*
 * Internal buses of the framer
 * pack_ctl_if  write strobes from control to the sample packer
 * time_if      time entries from control to the framer
 * word_if      sample words from the packer to the framer
 */
`timescale 1ns/100ps

// Same-cycle strobes, no handshake
interface pack_ctl_if;
   logic beat;
   logic pair_wr;
   logic pkt_last;
   logic odd_last;
   logic space;

   modport ctrl   (output beat, pair_wr, pkt_last, odd_last, input space);
   modport packer (input beat, pair_wr, pkt_last, odd_last, output space);
endinterface

interface time_if
   import pkt_pkg::*;
();
   pkt_time_t pkt_time;
   pkt_size_t size;
   logic      eob;
   logic      valid;
   logic      ready;

   modport source (output pkt_time, size, eob, valid, input ready);
   modport sink   (input pkt_time, size, eob, valid, output ready);
endinterface

interface word_if
   import pkt_pkg::*;
();
   word_t data;
   logic  last;
   logic  valid;
   logic  ready;

   modport source (output data, last, valid, input ready);
   modport sink   (input data, last, valid, output ready);
endinterface

// File: hdl/pkt_fifo.sv
/*
 * Synchronous first-word-fall-through FIFO
 * Register array with wrap-bit read and write pointers
 */
`timescale 1ns/100ps

module pkt_fifo #(
   parameter int WIDTH      = 8,
   parameter int DEPTH_LOG2 = 4
) (
   input  logic             clk,
   input  logic             rst,
   input  logic [WIDTH-1:0] wr_data,
   input  logic             wr_en,
   input  logic             rd_en,
   output logic [WIDTH-1:0] rd_data,
   output logic             not_full,
   output logic             not_empty
);

   logic [WIDTH-1:0]    mem [2**DEPTH_LOG2];
   // Extra top bit tells a full buffer from an empty one
   logic [DEPTH_LOG2:0] wr_ptr;
   logic [DEPTH_LOG2:0] rd_ptr;

   assign not_empty = (wr_ptr != rd_ptr);
   assign not_full  = !((wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]) &&
                        (wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]));

   // Head entry always visible
   assign rd_data = mem[rd_ptr[DEPTH_LOG2-1:0]];

   always_ff @(posedge clk) begin
      if (wr_en && not_full) begin
         mem[wr_ptr[DEPTH_LOG2-1:0]] <= wr_data;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_en && not_full) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         // Pop only a valid head
         if (rd_en && not_empty) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

endmodule

// File: hdl/pkt_ctrl.sv
/*
 * Input side control
 * Burst FSM counting down the remaining samples
 * Input FSM tracking pair phase and packet sample count
 * Timestamp and EOB generation, input ready and the time FIFO
 */
`timescale 1ns/100ps

module pkt_ctrl
   import pkt_pkg::*;
#(
   parameter int TIME_FIFO_LOG2 = 4
) (
   input  logic       clk,
   input  logic       rst,
   input  logic       enable,
   input  logic       in_valid,
   input  pkt_time_t  start_time,
   input  logic [15:0] time_per_pkt,
   input  pkt_size_t  packet_size,
   input  burst_cnt_t burst_size,
   output logic       in_ready,
   pack_ctl_if.ctrl   pack,
   time_if.source     tq
);

   // EOB flag, size in 32-bit words, timestamp
   localparam int TENTRY_W = 1 + $bits(pkt_size_t) + $bits(pkt_time_t);

   typedef enum logic {
      BURST_NEW,
      BURST_ACTIVE
   } burst_state_t;

   typedef enum logic [1:0] {
      IN_IDLE,
      IN_PAIR_A,
      IN_PAIR_B
   } in_state_t;

   burst_state_t        burst_state;
   in_state_t           in_state;
   burst_cnt_t          burst_count;
   pkt_size_t           in_count;
   pkt_time_t           pkt_time;
   pkt_time_t           time_now;
   logic                eob_q;
   logic                eob_hit;
   logic                eob_now;
   logic                beat;
   logic                first_beat;
   logic                burst_last;
   logic                pkt_end;
   logic                tfifo_not_full;
   logic                tfifo_not_empty;
   logic [TENTRY_W-1:0] tfifo_rd;

   // Space in both FIFOs and framing enabled
   assign in_ready   = enable && pack.space && tfifo_not_full;
   assign beat       = in_valid && in_ready;
   assign first_beat = (in_state == IN_IDLE);

   // Zero burst size runs forever
   assign burst_last = (burst_size != '0) && (burst_count == burst_cnt_t'(1));
   // Packet ends at full size or with the burst
   assign pkt_end    = (in_count >= packet_size) || burst_last;

   // Remaining samples judged at the start of a packet
   assign eob_hit = (burst_size != '0) && (burst_count <= burst_cnt_t'(packet_size));
   assign eob_now = first_beat ? eob_hit : eob_q;

   always_comb begin
      time_now = pkt_time;
      if (first_beat) begin
         // Burst start takes the programmed time
         if (burst_state == BURST_NEW) begin
            time_now = start_time;
         end else begin
            time_now = pkt_time + pkt_time_t'(time_per_pkt);
         end
      end
   end

   // ------------------------------------------------------------
   // Burst FSM
   // ------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst || !enable) begin
         burst_state <= BURST_NEW;
         burst_count <= burst_size;
      end else if (beat) begin
         if (burst_last) begin
            burst_state <= BURST_NEW;
            burst_count <= burst_size;
         end else begin
            burst_state <= BURST_ACTIVE;
            if (burst_size != '0) begin
               burst_count <= burst_count - 1'b1;
            end
         end
      end
   end

   // ------------------------------------------------------------
   // Input FSM
   // ------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         in_state <= IN_IDLE;
         in_count <= pkt_size_t'(1);
      end else if (beat) begin
         if (pkt_end) begin
            // Pairing restarts with every packet
            in_state <= IN_IDLE;
            in_count <= pkt_size_t'(1);
         end else begin
            in_state <= (in_state == IN_PAIR_B) ? IN_PAIR_A : IN_PAIR_B;
            in_count <= in_count + 1'b1;
         end
      end
   end

   // Snapshot time and EOB on the first beat of a packet
   always_ff @(posedge clk) begin
      if (beat && first_beat) begin
         pkt_time <= time_now;
         eob_q    <= eob_hit;
      end
   end

   // Word on second sample of a pair, or a lone last sample
   assign pack.beat     = beat;
   assign pack.pair_wr  = beat && ((in_state == IN_PAIR_B) || pkt_end);
   assign pack.pkt_last = beat && pkt_end;
   assign pack.odd_last = beat && pkt_end && (in_state != IN_PAIR_B);

   // One entry per packet, pushed with its last sample
   pkt_fifo #(
      .WIDTH      (TENTRY_W),
      .DEPTH_LOG2 (TIME_FIFO_LOG2)
   ) time_fifo (
      .clk       (clk),
      .rst       (rst),
      .wr_data   ({eob_now, in_count + pkt_size_t'(HEADER_WORDS), time_now}),
      .wr_en     (beat && pkt_end),
      .rd_en     (tq.ready),
      .rd_data   (tfifo_rd),
      .not_full  (tfifo_not_full),
      .not_empty (tfifo_not_empty)
   );

   assign {tq.eob, tq.size, tq.pkt_time} = tfifo_rd;
   assign tq.valid = tfifo_not_empty;

endmodule

// File: hdl/sample_packer.sv
/*
 * Sample packer
 * Holding register, pairing of two samples per word
 * and the sample FIFO carrying the packet last flag
 */
`timescale 1ns/100ps

module sample_packer
   import pkt_pkg::*;
#(
   parameter int SAMPLE_FIFO_LOG2 = 9
) (
   input  logic       clk,
   input  logic       rst,
   input  sample_t    in_data,
   pack_ctl_if.packer pack,
   word_if.source     words
);

   sample_t hold_q;
   word_t   pair_word;
   word_t   sfifo_data;
   logic    sfifo_last;
   logic    sfifo_not_empty;

   // Keep every accepted sample for the next pairing
   always_ff @(posedge clk) begin
      if (pack.beat) begin
         hold_q <= in_data;
      end
   end

   // Lone last sample of an odd packet fills both halves
   assign pair_word = pack.odd_last ? {in_data, in_data} : {hold_q, in_data};

   pkt_fifo #(
      .WIDTH      ($bits(word_t) + 1),
      .DEPTH_LOG2 (SAMPLE_FIFO_LOG2)
   ) sample_fifo (
      .clk       (clk),
      .rst       (rst),
      .wr_data   ({pack.pkt_last, pair_word}),
      .wr_en     (pack.pair_wr),
      .rd_en     (words.ready),
      .rd_data   ({sfifo_last, sfifo_data}),
      .not_full  (pack.space),
      .not_empty (sfifo_not_empty)
   );

   assign words.data  = sfifo_data;
   assign words.last  = sfifo_last;
   assign words.valid = sfifo_not_empty;

endmodule

// File: hdl/pkt_framer.sv
/*
 * Output framer
 * Header, time, samples FSM, sequence ID counter
 * and the output word multiplexer
 */
`timescale 1ns/100ps

module pkt_framer
   import pkt_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  logic     enable,
   input  flow_id_t flow_id,
   input  logic     out_ready,
   output word_t    out_data,
   output logic     out_valid,
   output logic     out_last,
   time_if.sink     tq,
   word_if.sink     words
);

   typedef enum logic [1:0] {
      OUT_HEADER,
      OUT_TIME,
      OUT_SAMPLES
   } out_state_t;

   out_state_t out_state;
   seq_id_t    seq_id;
   pkt_type_t  pkt_type;
   word_t      hdr_word;
   logic       out_beat;

   assign out_beat = out_valid && out_ready;

   // ------------------------------------------------------------
   // Header word
   // ------------------------------------------------------------
   assign pkt_type = tq.eob ? PKT_INT16_COMPLEX_EOB : PKT_INT16_COMPLEX;

   always_comb begin
      hdr_word = '0;
      hdr_word[HDR_TYPE_LSB +: $bits(pkt_type_t)] = pkt_type;
      hdr_word[HDR_SEQ_LSB +: $bits(seq_id_t)]    = seq_id;
      hdr_word[HDR_SIZE_LSB +: HDR_SIZE_W]        = HDR_SIZE_W'(tq.size);
      hdr_word[HDR_FLOW_LSB +: $bits(flow_id_t)]  = flow_id;
   end

   // ------------------------------------------------------------
   // Output FSM
   // ------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         out_state <= OUT_HEADER;
      end else if (out_beat) begin
         case (out_state)
            OUT_HEADER:  out_state <= OUT_TIME;
            OUT_TIME:    out_state <= OUT_SAMPLES;
            // Back to the next header after the last sample word
            OUT_SAMPLES: out_state <= words.last ? OUT_HEADER : OUT_SAMPLES;
            default:     out_state <= OUT_HEADER;
         endcase
      end
   end

   // Valid comes from the FIFO heads only
   always_comb begin
      out_data  = hdr_word;
      out_valid = tq.valid;
      out_last  = 1'b0;
      case (out_state)
         OUT_TIME: begin
            out_data = tq.pkt_time;
         end
         OUT_SAMPLES: begin
            out_data  = words.data;
            out_valid = words.valid;
            out_last  = words.last;
         end
         default: begin
            out_data = hdr_word;
         end
      endcase
   end

   // Time entry leaves with the time word
   assign tq.ready    = (out_state == OUT_TIME) && out_ready;
   assign words.ready = (out_state == OUT_SAMPLES) && out_ready;

   // Restarts from 0 while disabled
   always_ff @(posedge clk) begin
      if (rst || !enable) begin
         seq_id <= '0;
      end else if (out_beat && out_last) begin
         seq_id <= seq_id + 1'b1;
      end
   end

endmodule

// File: hdl/stream_to_pkt.sv
/*
 * Stream to packet framer, top level
 * Input control, sample packer and output framer
 * joined by the internal buses
 */
`timescale 1ns/100ps

module stream_to_pkt
   import pkt_pkg::*;
#(
   parameter int TIME_FIFO_LOG2   = 4,
   parameter int SAMPLE_FIFO_LOG2 = 9
) (
   input  logic        clk,
   input  logic        rst,
   // Control
   input  logic        enable,
   input  pkt_time_t   start_time,
   input  pkt_size_t   packet_size,
   input  flow_id_t    flow_id,
   input  logic [15:0] time_per_pkt,
   input  burst_cnt_t  burst_size,
   // Sample stream in
   input  sample_t     in_data,
   input  logic        in_valid,
   output logic        in_ready,
   // Packet stream out
   output word_t       out_data,
   output logic        out_valid,
   output logic        out_last,
   input  logic        out_ready
);

   pack_ctl_if pack_bus ();
   time_if     time_bus ();
   word_if     word_bus ();

   pkt_ctrl #(
      .TIME_FIFO_LOG2 (TIME_FIFO_LOG2)
   ) pkt_ctrl_i (
      .clk          (clk),
      .rst          (rst),
      .enable       (enable),
      .in_valid     (in_valid),
      .start_time   (start_time),
      .time_per_pkt (time_per_pkt),
      .packet_size  (packet_size),
      .burst_size   (burst_size),
      .in_ready     (in_ready),
      .pack         (pack_bus.ctrl),
      .tq           (time_bus.source)
   );

   sample_packer #(
      .SAMPLE_FIFO_LOG2 (SAMPLE_FIFO_LOG2)
   ) sample_packer_i (
      .clk     (clk),
      .rst     (rst),
      .in_data (in_data),
      .pack    (pack_bus.packer),
      .words   (word_bus.source)
   );

   pkt_framer pkt_framer_i (
      .clk       (clk),
      .rst       (rst),
      .enable    (enable),
      .flow_id   (flow_id),
      .out_ready (out_ready),
      .out_data  (out_data),
      .out_valid (out_valid),
      .out_last  (out_last),
      .tq        (time_bus.sink),
      .words     (word_bus.sink)
   );

endmodule

// File: sim/pkt_checker.sv
/*
 * Output stream checker for the packet framer testbench
 * Expected word queue filled by the reference model,
 * per-field comparison, hold check under back-pressure,
 * input refusal while disabled and the error count
 */
`timescale 1ns/100ps

module pkt_checker
   import pkt_pkg::*;
(
   input logic  clk,
   input logic  rst,
   input logic  enable,
   input logic  in_ready,
   input word_t out_data,
   input logic  out_valid,
   input logic  out_last,
   input logic  out_ready
);

   // Expected words with the last flag in the top bit
   logic [64:0] exp_q[$];
   int          errors;
   // Header is word 0 and the time word is word 1
   int          word_pos;
   logic        stalled;
   word_t       stall_data;
   logic        stall_last;

   initial begin
      errors   = 0;
      word_pos = 0;
      stalled  = 1'b0;
   end

   function automatic void add_word(word_t data, logic last);
      exp_q.push_back({last, data});
   endfunction

   function automatic int pending();
      return exp_q.size();
   endfunction

   function automatic int report_missing();
      if (exp_q.size() != 0) begin
         $display("%0d expected output words never appeared", exp_q.size());
      end
      return exp_q.size();
   endfunction

   function automatic void compare_field(string name, logic [63:0] got, logic [63:0] want);
      if (got !== want) begin
         $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, want);
         errors++;
      end
   endfunction

   // ------------------------------------------------------------
   // Output monitor
   // ------------------------------------------------------------
   always @(posedge clk) begin
      logic [64:0] want;
      if (rst) begin
         stalled  = 1'b0;
         word_pos = 0;
      end else begin
         // Input is refused while framing is disabled
         if (!enable && in_ready) begin
            $display("Mismatch at %0t: in_ready high while enable is low", $time);
            errors++;
         end
         // A stalled word stays put until out_ready takes it
         if (stalled && (!out_valid || out_data !== stall_data || out_last !== stall_last)) begin
            $display("Output word changed at %0t while waiting for out_ready", $time);
            errors++;
         end
         if (out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
               $display("Unexpected output word %h at %0t with nothing left to expect",
                        out_data, $time);
               errors++;
            end else begin
               want = exp_q.pop_front();
               if (word_pos == 0) begin
                  compare_field("header type", 64'(out_data[63:56]), 64'(want[63:56]));
                  compare_field("header seq id", 64'(out_data[55:48]), 64'(want[55:48]));
                  compare_field("header size", 64'(out_data[47:32]), 64'(want[47:32]));
                  compare_field("header flow id", 64'(out_data[31:0]), 64'(want[31:0]));
               end else if (word_pos == 1) begin
                  compare_field("timestamp", out_data, want[63:0]);
               end else begin
                  compare_field("sample word", out_data, want[63:0]);
               end
               compare_field("last flag", 64'(out_last), 64'(want[64]));
               // Expected last flag marks the packet boundary
               word_pos = want[64] ? 0 : word_pos + 1;
            end
         end
         stalled    = out_valid && !out_ready;
         stall_data = out_data;
         stall_last = out_last;
      end
   end

endmodule

// File: sim/tb_stream_to_pkt.sv
/*
 * Testbench for the stream to packet framer
 * Clock, reset, sample and back-pressure stimulus,
 * reference model of the output packets and the watchdog
 */
`timescale 1ns/100ps

module tb_stream_to_pkt
   import pkt_pkg::*;
();

   localparam int CLK_PERIOD = 20;
   localparam int SEED       = 32'hf234_2c76;
   // Sum of the sample counts of all sessions below
   localparam int TOTAL_SAMPLES   = 362;
   localparam int WATCHDOG_CYCLES = TOTAL_SAMPLES * 40 + 2000;

   logic        clk;
   logic        rst;
   logic        enable;
   pkt_time_t   start_time;
   pkt_size_t   packet_size;
   flow_id_t    flow_id;
   logic [15:0] time_per_pkt;
   burst_cnt_t  burst_size;
   sample_t     in_data;
   logic        in_valid;
   logic        in_ready;
   word_t       out_data;
   logic        out_valid;
   logic        out_last;
   logic        out_ready;

   int          sample_idx;
   // Percent of cycles with out_ready low
   int          ready_gap;
   int          missing;

   stream_to_pkt stream_to_pkt_i (
      .clk          (clk),
      .rst          (rst),
      .enable       (enable),
      .start_time   (start_time),
      .packet_size  (packet_size),
      .flow_id      (flow_id),
      .time_per_pkt (time_per_pkt),
      .burst_size   (burst_size),
      .in_data      (in_data),
      .in_valid     (in_valid),
      .in_ready     (in_ready),
      .out_data     (out_data),
      .out_valid    (out_valid),
      .out_last     (out_last),
      .out_ready    (out_ready)
   );

   pkt_checker pkt_checker_i (
      .clk       (clk),
      .rst       (rst),
      .enable    (enable),
      .in_ready  (in_ready),
      .out_data  (out_data),
      .out_valid (out_valid),
      .out_last  (out_last),
      .out_ready (out_ready)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   // Random back-pressure on the output
   always @(posedge clk) begin
      out_ready <= (($urandom % 100) >= ready_gap);
   end

   // I is the running index and Q its inverse
   function automatic sample_t make_sample(int idx);
      logic [15:0] i_part;
      i_part = idx[15:0];
      return {i_part, ~i_part};
   endfunction

   // ------------------------------------------------------------
   // Reference model of one enabled session from sequence ID 0
   // ------------------------------------------------------------
   function automatic void expect_packets(pkt_time_t t0, logic [15:0] tpp, int psize,
                                          int bsize, flow_id_t flow, int first_idx,
                                          int count);
      int        done;
      int        n;
      int        k;
      int        seq;
      int        remaining;
      logic      new_burst;
      logic      eob;
      logic [7:0] ptype;
      pkt_time_t t;
      sample_t   a;
      sample_t   b;
      done      = 0;
      seq       = 0;
      remaining = bsize;
      new_burst = 1'b1;
      t         = t0;
      while (done < count) begin
         // Burst size zero never ends a burst
         n   = (bsize != 0 && remaining < psize) ? remaining : psize;
         eob = (bsize != 0) && (remaining <= psize);
         t   = new_burst ? t0 : t + pkt_time_t'(tpp);
         ptype = eob ? 8'h17 : 8'h16;
         pkt_checker_i.add_word({ptype, seq[7:0], 16'(n + 4), flow}, 1'b0);
         pkt_checker_i.add_word(t, 1'b0);
         // Pairs restart at each packet and a lone sample fills both halves
         for (k = 0; k < n; k += 2) begin
            a = make_sample(first_idx + done + k);
            b = (k + 1 < n) ? make_sample(first_idx + done + k + 1) : a;
            pkt_checker_i.add_word({a, b}, (k + 2 >= n));
         end
         done += n;
         seq++;
         new_burst = 1'b0;
         if (bsize != 0) begin
            remaining -= n;
            if (remaining == 0) begin
               remaining = bsize;
               new_burst = 1'b1;
            end
         end
      end
   endfunction

   // Offer samples with random in_valid gaps until count have moved
   task automatic drive_samples(int count, int valid_gap);
      int sent;
      sent = 0;
      while (sent < count) begin
         in_valid <= (($urandom % 100) >= valid_gap);
         in_data  <= make_sample(sample_idx);
         @(posedge clk);
         if (in_valid && in_ready) begin
            sent++;
            sample_idx++;
         end
      end
      in_valid <= 1'b0;
   endtask

   task automatic run_session(pkt_time_t t0, logic [15:0] tpp, int psize, int bsize,
                              flow_id_t flow, int count, int valid_gap, int rgap);
      expect_packets(t0, tpp, psize, bsize, flow, sample_idx, count);
      @(posedge clk);
      start_time   <= t0;
      time_per_pkt <= tpp;
      packet_size  <= pkt_size_t'(psize);
      burst_size   <= burst_cnt_t'(bsize);
      flow_id      <= flow;
      ready_gap    <= rgap;
      // Burst count reloads from the new burst size before enable rises
      @(posedge clk);
      enable       <= 1'b1;
      drive_samples(count, valid_gap);
      // Let the output drain before dropping enable
      while (pkt_checker_i.pending() != 0) begin
         @(posedge clk);
      end
      ready_gap <= 0;
      enable    <= 1'b0;
      repeat (4) @(posedge clk);
   endtask

   initial begin
      void'($urandom(SEED));
      rst          = 1'b1;
      enable       = 1'b0;
      start_time   = '0;
      packet_size  = '0;
      flow_id      = '0;
      time_per_pkt = '0;
      burst_size   = '0;
      in_data      = '0;
      in_valid     = 1'b0;
      out_ready    = 1'b0;
      ready_gap    = 0;
      sample_idx   = 0;
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      // Even packets, endless burst, no stalls
      run_session(64'h0000_0100_0000_0000, 16'd100, 8, 0, 32'h0000_f001, 64, 0, 0);
      // Odd packets
      run_session(64'h0000_0000_0010_0000, 16'd5, 5, 0, 32'h0000_f002, 40, 0, 0);
      // Bursts of 20 with the third packet EOB
      run_session(64'h0000_0200_0000_0400, 16'd1000, 8, 20, 32'h0000_f003, 60, 0, 0);
      // Input gaps and heavy back-pressure fill the time FIFO
      run_session(64'h1234_5678_0000_0000, 16'd3, 3, 10, 32'h0000_f004, 150, 25, 60);
      // Same settings twice across an enable drop
      run_session(64'h0000_0000_00ab_0000, 16'd64, 6, 0, 32'h0000_f005, 24, 10, 20);
      run_session(64'h0000_0000_00ab_0000, 16'd64, 6, 0, 32'h0000_f005, 24, 10, 20);
      missing = pkt_checker_i.report_missing();
      $display("Checks done: %0d errors, %0d words missing", pkt_checker_i.errors, missing);
      if (pkt_checker_i.errors == 0 && missing == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles before all sessions finished",
               WATCHDOG_CYCLES);
      $display("test failed");
      $finish;
   end

endmodule

// File: src.f
hdl/pkt_pkg.sv
hdl/pkt_ifs.sv
hdl/pkt_fifo.sv
hdl/pkt_ctrl.sv
hdl/sample_packer.sv
hdl/pkt_framer.sv
hdl/stream_to_pkt.sv
sim/pkt_checker.sv
sim/tb_stream_to_pkt.sv
